//--- cluster_data_router.sv
// Lanes arrive one cycle ahead of bank_data and are aligned here; output is 3 cycles after banks
`timescale 1ns/100ps
`include "grom_params.svh"

module cluster_data_router (
  input  logic                clk,
  input  logic                rst,
  input  grom_pkg::data_vec_t bank_data,
  input  grom_pkg::lane_vec_t lane_x,
  input  grom_pkg::lane_vec_t lane_y,
  input  grom_pkg::lane_vec_t lane_z,
  output grom_pkg::data_vec_t rdata
);

  // Lanes lined up with the bank read
  grom_pkg::lane_vec_t lx_b, ly_b, lz_b;

  // After z rotation
  grom_pkg::data_vec_t d_z;
  grom_pkg::lane_vec_t lx_z, ly_z;

  // After y rotation
  grom_pkg::data_vec_t d_y;
  grom_pkg::lane_vec_t lx_y;

  always_ff @(posedge clk) begin
    if (rst) begin
      lx_b  <= '0;
      ly_b  <= '0;
      lz_b  <= '0;
      d_z   <= '0;
      lx_z  <= '0;
      ly_z  <= '0;
      d_y   <= '0;
      lx_y  <= '0;
      rdata <= '0;
    end else begin
      lx_b <= lane_x;
      ly_b <= lane_y;
      lz_b <= lane_z;
      for (int s = 0; s < `GROM_NNN3D; s++) begin
        // ----------------------------------------
        // z, then y, then x rotation
        // ----------------------------------------
        d_z[s]   <= bank_data[{lz_b[s], s[1:0]}];
        d_y[s]   <= d_z[{s[2], ly_z[s], s[0]}];
        rdata[s] <= d_y[{s[2:1], lx_y[s]}];
      end
      // Unconsumed lanes travel with the data
      lx_z <= lx_b;
      ly_z <= ly_b;
      lx_y <= lx_z;
    end
  end

endmodule

//--- cluster_req_router.sv
// Assumes every enabled port sits on a distinct lane triple; overlapping requests are not detected
`timescale 1ns/100ps
`include "grom_params.svh"

module cluster_req_router (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`GROM_NNN3D-1:0]  me,
  input  grom_pkg::coord_vec_t    coords_x,
  input  grom_pkg::coord_vec_t    coords_y,
  input  grom_pkg::coord_vec_t    coords_z,
  output logic [`GROM_NNN3D-1:0]  bank_me,
  output grom_pkg::addr_vec_t     bank_addr,
  output grom_pkg::lane_vec_t     lane_x,
  output grom_pkg::lane_vec_t     lane_y,
  output grom_pkg::lane_vec_t     lane_z
);

  // Split view of the incoming coordinates
  grom_pkg::cid_vec_t  cx_in, cy_in, cz_in;
  grom_pkg::lane_vec_t lx_in, ly_in, lz_in;

  // Stage x results and next state
  logic [`GROM_NNN3D-1:0] me_sx, me_sx_nxt;
  grom_pkg::cid_vec_t     cx_sx, cy_sx, cz_sx, cx_sx_nxt, cy_sx_nxt, cz_sx_nxt;
  grom_pkg::lane_vec_t    ly_sx, lz_sx, ly_sx_nxt, lz_sx_nxt;

  // Stage y
  logic [`GROM_NNN3D-1:0] me_sy, me_sy_nxt;
  grom_pkg::cid_vec_t     cx_sy, cy_sy, cz_sy, cx_sy_nxt, cy_sy_nxt, cz_sy_nxt;
  grom_pkg::lane_vec_t    lz_sy, lz_sy_nxt;

  // Stage z
  logic [`GROM_NNN3D-1:0] me_sz_nxt;
  grom_pkg::cid_vec_t     cx_sz_nxt, cy_sz_nxt, cz_sz_nxt;

  // Lanes of the original ports, delayed for the return path
  grom_pkg::lane_vec_t    lx_d1, ly_d1, lz_d1, lx_d2, ly_d2, lz_d2;

  always_comb begin
    for (int p = 0; p < `GROM_NNN3D; p++) begin
      cx_in[p] = coords_x[p].split.cid;
      cy_in[p] = coords_y[p].split.cid;
      cz_in[p] = coords_z[p].split.cid;
      lx_in[p] = coords_x[p].split.lane;
      ly_in[p] = coords_y[p].split.lane;
      lz_in[p] = coords_z[p].split.lane;
    end
  end

  // ----------------------------------------
  // Request muxes, one axis per stage
  // ----------------------------------------
  always_comb begin
    int src;
    me_sx_nxt = '0;
    cx_sx_nxt = '0;
    cy_sx_nxt = '0;
    cz_sx_nxt = '0;
    ly_sx_nxt = '0;
    lz_sx_nxt = '0;
    for (int s = 0; s < `GROM_NNN3D; s++) begin
      for (int i = 0; i < `GROM_NNN1D; i++) begin
        // Same z and y, walk the x neighbors
        src = (s & 6) | i;
        if (me[src] && (lx_in[src] == s[0])) begin
          me_sx_nxt[s] = 1'b1;
          cx_sx_nxt[s] = cx_in[src];
          cy_sx_nxt[s] = cy_in[src];
          cz_sx_nxt[s] = cz_in[src];
          ly_sx_nxt[s] = ly_in[src];
          lz_sx_nxt[s] = lz_in[src];
        end
      end
    end
  end

  always_comb begin
    int src;
    me_sy_nxt = '0;
    cx_sy_nxt = '0;
    cy_sy_nxt = '0;
    cz_sy_nxt = '0;
    lz_sy_nxt = '0;
    for (int s = 0; s < `GROM_NNN3D; s++) begin
      for (int i = 0; i < `GROM_NNN1D; i++) begin
        src = (s & 5) | (i << 1);
        if (me_sx[src] && (ly_sx[src] == s[1])) begin
          me_sy_nxt[s] = 1'b1;
          cx_sy_nxt[s] = cx_sx[src];
          cy_sy_nxt[s] = cy_sx[src];
          cz_sy_nxt[s] = cz_sx[src];
          lz_sy_nxt[s] = lz_sx[src];
        end
      end
    end
  end

  always_comb begin
    int src;
    me_sz_nxt = '0;
    cx_sz_nxt = '0;
    cy_sz_nxt = '0;
    cz_sz_nxt = '0;
    for (int s = 0; s < `GROM_NNN3D; s++) begin
      for (int i = 0; i < `GROM_NNN1D; i++) begin
        src = (s & 3) | (i << 2);
        if (me_sy[src] && (lz_sy[src] == s[2])) begin
          me_sz_nxt[s] = 1'b1;
          cx_sz_nxt[s] = cx_sy[src];
          cy_sz_nxt[s] = cy_sy[src];
          cz_sz_nxt[s] = cz_sy[src];
        end
      end
    end
  end

  // ----------------------------------------
  // Pipeline registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      me_sx     <= '0;
      cx_sx     <= '0;
      cy_sx     <= '0;
      cz_sx     <= '0;
      ly_sx     <= '0;
      lz_sx     <= '0;
      me_sy     <= '0;
      cx_sy     <= '0;
      cy_sy     <= '0;
      cz_sy     <= '0;
      lz_sy     <= '0;
      bank_me   <= '0;
      bank_addr <= '0;
      lx_d1     <= '0;
      ly_d1     <= '0;
      lz_d1     <= '0;
      lx_d2     <= '0;
      ly_d2     <= '0;
      lz_d2     <= '0;
      lane_x    <= '0;
      lane_y    <= '0;
      lane_z    <= '0;
    end else begin
      me_sx   <= me_sx_nxt;
      cx_sx   <= cx_sx_nxt;
      cy_sx   <= cy_sx_nxt;
      cz_sx   <= cz_sx_nxt;
      ly_sx   <= ly_sx_nxt;
      lz_sx   <= lz_sx_nxt;
      me_sy   <= me_sy_nxt;
      cx_sy   <= cx_sy_nxt;
      cy_sy   <= cy_sy_nxt;
      cz_sy   <= cz_sy_nxt;
      lz_sy   <= lz_sy_nxt;
      bank_me <= me_sz_nxt;
      // Bank address is {z, y, x} cluster index
      for (int s = 0; s < `GROM_NNN3D; s++) begin
        bank_addr[s] <= {cz_sz_nxt[s], cy_sz_nxt[s], cx_sz_nxt[s]};
      end
      lx_d1  <= lx_in;
      ly_d1  <= ly_in;
      lz_d1  <= lz_in;
      lx_d2  <= lx_d1;
      ly_d2  <= ly_d1;
      lz_d2  <= lz_d1;
      lane_x <= lx_d2;
      lane_y <= ly_d2;
      lane_z <= lz_d2;
    end
  end

endmodule

//--- clustered_greens_rom.f
+incdir+.
grom_pkg.sv
cluster_req_router.sv
greens_bank_array.sv
cluster_data_router.sv
clustered_greens_rom.sv
clustered_greens_rom_tb.sv

//--- clustered_greens_rom.sv
// Seven cycle read latency, one cluster per cycle, no back-pressure; clusters must be legal
`timescale 1ns/100ps
`include "grom_params.svh"

module clustered_greens_rom (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`GROM_NNN3D-1:0] me,
  input  grom_pkg::coord_vec_t   coords_x,
  input  grom_pkg::coord_vec_t   coords_y,
  input  grom_pkg::coord_vec_t   coords_z,
  output grom_pkg::data_vec_t    rdata
);

  logic [`GROM_NNN3D-1:0] bank_me;
  grom_pkg::addr_vec_t    bank_addr;
  grom_pkg::data_vec_t    bank_data;
  grom_pkg::lane_vec_t    lane_x, lane_y, lane_z;

  // Requests onto banks, 3 cycles
  cluster_req_router req_router_i (
    .clk       (clk),
    .rst       (rst),
    .me        (me),
    .coords_x  (coords_x),
    .coords_y  (coords_y),
    .coords_z  (coords_z),
    .bank_me   (bank_me),
    .bank_addr (bank_addr),
    .lane_x    (lane_x),
    .lane_y    (lane_y),
    .lane_z    (lane_z)
  );

  greens_bank_array bank_array_i (
    .clk       (clk),
    .rst       (rst),
    .bank_me   (bank_me),
    .bank_addr (bank_addr),
    .bank_data (bank_data)
  );

  // Words back to ports, 3 cycles
  cluster_data_router data_router_i (
    .clk       (clk),
    .rst       (rst),
    .bank_data (bank_data),
    .lane_x    (lane_x),
    .lane_y    (lane_y),
    .lane_z    (lane_z),
    .rdata     (rdata)
  );

endmodule

//--- clustered_greens_rom_tb.sv
// Drives only legal clusters and checks enabled ports 7 cycles later; all-off cycles reuse the last coordinates
`timescale 1ns/100ps
`include "grom_params.svh"

module clustered_greens_rom_tb;

  localparam int KIND_ZERO  = 0;
  localparam int KIND_PORTS = 1;
  localparam int KIND_HOLD  = 2;

  logic                   clk;
  logic                   rst;
  logic [`GROM_NNN3D-1:0] me;
  grom_pkg::coord_vec_t   coords_x;
  grom_pkg::coord_vec_t   coords_y;
  grom_pkg::coord_vec_t   coords_z;
  grom_pkg::data_vec_t    rdata;

  // Expected results in flight, one entry per driven cycle
  grom_pkg::data_vec_t    exp_q[$];
  logic [`GROM_NNN3D-1:0] mask_q[$];
  int                     kind_q[$];
  int                     due_q[$];

  grom_pkg::data_vec_t    prev_rdata;
  int                     cycle;
  int                     seed;
  int                     perm[`GROM_NNN3D];

  clustered_greens_rom dut_i (
    .clk      (clk),
    .rst      (rst),
    .me       (me),
    .coords_x (coords_x),
    .coords_y (coords_y),
    .coords_z (coords_z),
    .rdata    (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic int wrap_dist(input int c);
    return (c <= `GROM_GSIZE1D / 2) ? c : `GROM_GSIZE1D - c;
  endfunction

  function automatic logic [31:0] model_green(input int x, input int y, input int z);
    int r2;
    r2 = wrap_dist(x) * wrap_dist(x) + wrap_dist(y) * wrap_dist(y) + wrap_dist(z) * wrap_dist(z);
    return 32'((1 << 24) / (r2 + 1));
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_rdata_zero();
    for (int p = 0; p < `GROM_NNN3D; p++) begin
      assert (rdata[p] === '0)
        else report_mismatch($sformatf("rdata[%0d]", p), '0, rdata[p]);
    end
  endtask

  task automatic queue_expect(input grom_pkg::data_vec_t exp, input logic [7:0] mask,
                              input int kind);
    exp_q.push_back(exp);
    mask_q.push_back(mask);
    kind_q.push_back(kind);
    due_q.push_back(cycle + `GROM_LATENCY);
  endtask

  // Port p gets lane triple perm[p] as offset from the base, wrapping at the grid edge
  task automatic drive_cluster(input logic [7:0] en, input int bx, input int by, input int bz,
                               input int kind);
    grom_pkg::data_vec_t exp;
    int x;
    int y;
    int z;
    for (int p = 0; p < `GROM_NNN3D; p++) begin
      x = (bx + (perm[p] & 1)) % `GROM_GSIZE1D;
      y = (by + ((perm[p] >> 1) & 1)) % `GROM_GSIZE1D;
      z = (bz + ((perm[p] >> 2) & 1)) % `GROM_GSIZE1D;
      coords_x[p].raw = `GROM_COORDW'(x);
      coords_y[p].raw = `GROM_COORDW'(y);
      coords_z[p].raw = `GROM_COORDW'(z);
      exp[p] = model_green(x, y, z);
    end
    me = en;
    queue_expect(exp, en, kind);
  endtask

  // All ports off with unchanged coordinates
  task automatic drive_hold();
    me = '0;
    queue_expect('0, '0, KIND_HOLD);
  endtask

  task automatic check_outputs();
    grom_pkg::data_vec_t exp;
    logic [7:0]          mask;
    int                  kind;
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      exp  = exp_q.pop_front();
      mask = mask_q.pop_front();
      kind = kind_q.pop_front();
      void'(due_q.pop_front());
      for (int p = 0; p < `GROM_NNN3D; p++) begin
        if (kind == KIND_ZERO) begin
          assert (rdata[p] === '0)
            else report_mismatch($sformatf("rdata[%0d]", p), '0, rdata[p]);
        end else if (kind == KIND_HOLD) begin
          assert (rdata[p] === prev_rdata[p])
            else report_mismatch($sformatf("rdata[%0d]", p), prev_rdata[p], rdata[p]);
        end else if (mask[p]) begin
          assert (rdata[p] === exp[p])
            else report_mismatch($sformatf("rdata[%0d]", p), exp[p], rdata[p]);
        end
      end
    end
    prev_rdata = rdata;
  endtask

  // Outputs are read 1 ns after the edge, then new inputs follow
  task automatic step_cycle();
    @(posedge clk);
    #1;
    cycle++;
    check_outputs();
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int   r;
    int   guard;
    logic [7:0] en;
    seed       = 29791;
    cycle      = 0;
    rst        = 1'b1;
    me         = '0;
    coords_x   = '0;
    coords_y   = '0;
    coords_z   = '0;
    prev_rdata = '0;
    for (int p = 0; p < `GROM_NNN3D; p++) begin
      perm[p] = p;
    end
    repeat (16) @(posedge clk);
    #1;
    check_rdata_zero();
    rst = 1'b0;

    // Idle after reset, output must stay zero
    drive_cluster('0, 0, 0, 0, KIND_ZERO);
    repeat (6) begin
      step_cycle();
      check_rdata_zero();
      drive_cluster('0, 0, 0, 0, KIND_ZERO);
    end

    // Single port at the origin
    step_cycle();
    drive_cluster(8'h01, 0, 0, 0, KIND_PORTS);

    // Full clusters, identity order, plain and wrapping base
    step_cycle();
    drive_cluster(8'hff, 0, 0, 0, KIND_PORTS);
    step_cycle();
    drive_cluster(8'hff, 7, 7, 7, KIND_PORTS);
    step_cycle();
    drive_cluster(8'hff, 3, 6, 1, KIND_PORTS);

    // Random back-to-back clusters
    for (int n = 0; n < 400; n++) begin
      step_cycle();
      r = $random(seed);
      if (r[3:0] == 4'd0) begin
        drive_hold();
      end else begin
        // Offset order is the cluster rotated on each axis by a random lane flip
        for (int p = 0; p < `GROM_NNN3D; p++) begin
          perm[p] = p ^ int'(r[27:25]);
        end
        en = r[4] ? 8'hff : r[15:8];
        drive_cluster(en, r[18:16], r[21:19], r[24:22], KIND_PORTS);
      end
    end

    // Drain the pipeline
    step_cycle();
    me    = '0;
    guard = 0;
    while (due_q.size() > 0 && guard < `GROM_LATENCY + 2) begin
      step_cycle();
      guard++;
    end
    if (due_q.size() > 0) begin
      $display("Timed out waiting for %0d outstanding results", due_q.size());
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

//--- greens_bank_array.sv
// Read-only banks; a disabled bank keeps its last word on bank_data
`timescale 1ns/100ps
`include "grom_params.svh"

module greens_bank_array (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`GROM_NNN3D-1:0] bank_me,
  input  grom_pkg::addr_vec_t    bank_addr,
  output grom_pkg::data_vec_t    bank_data
);

  typedef logic [`GROM_BDEPTH-1:0][`GROM_GELEW-1:0] bank_img_t;

  // Contents of bank (zl, yl, xl), built from the cluster grid position
  function automatic bank_img_t bank_image(input int zl, input int yl, input int xl);
    bank_img_t        img;
    grom_pkg::coord_t cx;
    grom_pkg::coord_t cy;
    grom_pkg::coord_t cz;
    for (int a = 0; a < `GROM_BDEPTH; a++) begin
      cz.raw = `GROM_COORDW'((a >> 4) * `GROM_NNN1D + zl);
      cy.raw = `GROM_COORDW'(((a >> 2) & 3) * `GROM_NNN1D + yl);
      cx.raw = `GROM_COORDW'((a & 3) * `GROM_NNN1D + xl);
      img[a] = grom_pkg::greens_value(cx.raw, cy.raw, cz.raw);
    end
    return img;
  endfunction

  // ----------------------------------------
  // One ROM per lane combination
  // ----------------------------------------
  for (genvar b = 0; b < `GROM_NNN3D; b++) begin : g_bank
    localparam bank_img_t ROM = bank_image((b >> 2) & 1, (b >> 1) & 1, b & 1);

    always_ff @(posedge clk) begin
      if (rst) begin
        bank_data[b] <= '0;
      end else if (bank_me[b]) begin
        bank_data[b] <= ROM[bank_addr[b]];
      end
    end
  end

endmodule

//--- grom_params.svh
// Fixed 8x8x8 grid with 2x2x2 clusters; changing sizes needs matching widths in every macro
`ifndef GROM_PARAMS_SVH
`define GROM_PARAMS_SVH

// ----------------------------------------
// Grid geometry
// ----------------------------------------
`define GROM_GSIZE1D 8
`define GROM_NNN1D   2
`define GROM_NNN3D   8

// Coordinate field widths
`define GROM_COORDW  3
`define GROM_LANEW   1
`define GROM_CIDW    2

// ----------------------------------------
// Bank storage
// ----------------------------------------
`define GROM_BADDRW  6
`define GROM_BDEPTH  64
`define GROM_GELEW   32

// Request to read data, in clock cycles
`define GROM_LATENCY 7

`endif

//--- grom_pkg.sv
// Types and Green's value model for the 8x8x8 ROM; port index is z*4 + y*2 + x
`include "grom_params.svh"

package grom_pkg;

  // ----------------------------------------
  // Coordinate views
  // ----------------------------------------
  // One axis coordinate, either whole or as cluster index plus lane
  typedef struct packed {
    logic [`GROM_CIDW-1:0]  cid;
    logic [`GROM_LANEW-1:0] lane;
  } coord_split_t;

  typedef union packed {
    logic [`GROM_COORDW-1:0] raw;
    coord_split_t            split;
  } coord_t;

  // ----------------------------------------
  // Per-port vectors
  // ----------------------------------------
  typedef coord_t [`GROM_NNN3D-1:0]                         coord_vec_t;
  typedef logic   [`GROM_NNN3D-1:0]                         lane_vec_t;
  typedef logic   [`GROM_NNN3D-1:0][`GROM_CIDW-1:0]         cid_vec_t;
  typedef logic   [`GROM_NNN3D-1:0][`GROM_BADDRW-1:0]       addr_vec_t;
  typedef logic   [`GROM_NNN3D-1:0][`GROM_GELEW-1:0]        data_vec_t;

  // ----------------------------------------
  // Green's function sample
  // ----------------------------------------
  // Periodic distance on one axis
  function automatic int unsigned axis_dist(input logic [`GROM_COORDW-1:0] c);
    int unsigned cv;
    int unsigned wrap;
    cv   = int'(c);
    wrap = `GROM_GSIZE1D - cv;
    return (cv < wrap) ? cv : wrap;
  endfunction

  // Fixed point 2^24 / (1 + r^2)
  function automatic logic [`GROM_GELEW-1:0] greens_value(
    input logic [`GROM_COORDW-1:0] x,
    input logic [`GROM_COORDW-1:0] y,
    input logic [`GROM_COORDW-1:0] z
  );
    int unsigned dx;
    int unsigned dy;
    int unsigned dz;
    int unsigned r2;
    dx = axis_dist(x);
    dy = axis_dist(y);
    dz = axis_dist(z);
    r2 = dx * dx + dy * dy + dz * dz;
    return `GROM_GELEW'((32'd1 << 24) / (r2 + 1));
  endfunction

endpackage
